// ==== filelist.f ====
hdl/fm_reg_pkg.sv
hdl/fm_slot_counter.sv
hdl/fm_op_regs.sv
hdl/fm_ch_regs.sv
hdl/fm_slot_mux.sv
hdl/fm_reg_top.sv
verif/fm_reg_properties.sv
verif/fm_reg_tb.sv

// ==== hdl/fm_ch_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_ch_regs import fm_reg_pkg::*; #(
	parameter int CH_STAGES = 6
) (
	input  wire        clk,
	input  wire        reset,
	input  wire        clk_en,
	input  wire  [7:0] din,
	input  ch_t        ch,
	input  ch_t        cur_ch,
	input  wire  [5:0] latch_fnum,
	input  wire        up_alg_fb,
	input  wire        up_fnum_lo,
	input  wire        up_pan_pms,
	output fnum_t      fnum_raw,
	output block_t     block_raw,
	output alg_t       alg,
	output fb_t        fb,
	output ams_t       ams,
	output pms_t       pms,
	output pan_t       pan
);

	ch_word_t ring [CH_STAGES];
	pan_t     pan_ring [CH_STAGES];
	ch_word_t ring_in;
	pan_t     pan_in;
	logic     ch_hit;

	// one stage per channel, last stage is the current channel
	assign {block_raw, fnum_raw, fb, alg, ams, pms} = ring[CH_STAGES-1];
	assign pan = pan_ring[CH_STAGES-1];

	assign ch_hit = cur_ch == ch;

	// low byte write pulls in block and fnum high bits from the latch
	assign ring_in = {
		(up_fnum_lo && ch_hit) ? {latch_fnum, din} : {block_raw, fnum_raw},
		(up_alg_fb  && ch_hit) ? din[5:0]          : {fb, alg},
		(up_pan_pms && ch_hit) ? din[5:4]          : ams,
		(up_pan_pms && ch_hit) ? din[2:0]          : pms
	};

	// pan shares the byte with ams and pms
	assign pan_in = (up_pan_pms && ch_hit) ? din[7:6] : pan;

	always_ff @(posedge clk) begin
		if (reset) begin
			// all stages at once
			for (int i = 0; i < CH_STAGES; i++) begin
				ring[i]     <= '0;
				pan_ring[i] <= PAN_RESET;
			end
		end else if (clk_en) begin
			ring[0]     <= ring_in;
			pan_ring[0] <= pan_in;
			for (int i = 1; i < CH_STAGES; i++) begin
				ring[i]     <= ring[i-1];
				pan_ring[i] <= pan_ring[i-1];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fm_op_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_op_regs import fm_reg_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	input  wire        clk_en,
	input  wire  [7:0] din,
	input  ch_t        ch,
	input  op_t        op,
	input  op_t        cur_op,
	input  ch_t        cur_ch,
	input  op_t        nxt_op,
	input  ch_t        nxt_ch,
	input  wire        up_dt_mul,
	input  wire        up_tl,
	input  wire        up_ks_ar,
	input  wire        up_am_dr,
	input  wire        up_sr,
	input  wire        up_sl_rr,
	input  wire        up_ssg,
	output tl_t        tl,
	output dt_t        dt1,
	output nib_t       mul,
	output ks_t        ks,
	output rate_t      ar,
	output logic       amen,
	output rate_t      d1r,
	output rate_t      d2r,
	output nib_t       sl,
	output nib_t       rr,
	output logic       ssg_en,
	output block_t     ssg_eg
);

	// tl at max, everything else cleared
	localparam op_word_t RESET_WORD = {TL_RESET, 37'd0};

	op_word_t mem [SLOTS];
	op_word_t rd_word;
	op_word_t wr_word;
	op_word_t upd_word;
	slot_t    wr_addr;
	slot_t    rd_addr;
	logic     op_hit;
	logic     fill_pending;

	// channels 4..6 fold onto index 3..5
	function automatic slot_t slot_addr(input op_t o, input ch_t c);
		ch_t idx;
		idx = c[2] ? c - 3'd1 : c;
		return slot_t'({o, 2'b00}) + slot_t'({o, 1'b0}) + slot_t'(idx);
	endfunction

	// write where the sequencer is, read where it goes
	assign wr_addr = slot_addr(cur_op, cur_ch);
	assign rd_addr = slot_addr(nxt_op, nxt_ch);

	// request targets the slot now passing
	assign op_hit = (cur_op == op) && (cur_ch == ch);

	// word field by field, din slices follow the chip register map
	assign upd_word = {
		(up_tl     && op_hit) ? din[6:0] : tl,
		(up_dt_mul && op_hit) ? din[6:4] : dt1,
		(up_dt_mul && op_hit) ? din[3:0] : mul,
		(up_ks_ar  && op_hit) ? din[7:6] : ks,
		(up_ks_ar  && op_hit) ? din[4:0] : ar,
		(up_am_dr  && op_hit) ? din[7]   : amen,
		(up_am_dr  && op_hit) ? din[4:0] : d1r,
		(up_sr     && op_hit) ? din[4:0] : d2r,
		(up_sl_rr  && op_hit) ? din[7:4] : sl,
		(up_sl_rr  && op_hit) ? din[3:0] : rr,
		(up_ssg    && op_hit) ? din[3]   : ssg_en,
		(up_ssg    && op_hit) ? din[2:0] : ssg_eg
	};

	assign wr_word = (reset || fill_pending) ? RESET_WORD : upd_word;

	// reset word keeps going in until the round after reset is done
	always_ff @(posedge clk) begin
		if (reset) begin
			fill_pending <= 1'b1;
		end else if (clk_en && (nxt_op == OP_S1) && (nxt_ch == 3'd0)) begin
			fill_pending <= 1'b0;
		end
	end

	// read and write addresses always differ by one slot
	always_ff @(posedge clk) begin
		if (clk_en) begin
			mem[wr_addr] <= wr_word;
			rd_word      <= mem[rd_addr];
		end
	end

	// rd_word holds the word of the current slot
	assign {tl, dt1, mul, ks, ar, amen, d1r, d2r, sl, rr, ssg_en, ssg_eg} = rd_word;

endmodule

`default_nettype wire

// ==== hdl/fm_reg_pkg.sv ====
`default_nettype none

package fm_reg_pkg;

	// slot coordinates
	typedef logic [1:0] op_t;
	// codes 3 and 7 never appear on the sequencer
	typedef logic [2:0] ch_t;
	// flat operator memory address, op*6 + channel index
	typedef logic [4:0] slot_t;

	// channel fields
	typedef logic [10:0] fnum_t;
	typedef logic [2:0]  block_t;
	typedef logic [2:0]  alg_t;
	typedef logic [2:0]  fb_t;
	typedef logic [1:0]  pan_t;
	typedef logic [1:0]  ams_t;
	typedef logic [2:0]  pms_t;

	// operator fields
	typedef logic [6:0] tl_t;
	typedef logic [4:0] rate_t;
	typedef logic [3:0] nib_t;
	typedef logic [2:0] dt_t;
	typedef logic [1:0] ks_t;

	// tl dt1 mul ks ar amen d1r d2r sl rr ssg_en ssg_eg
	typedef logic [43:0] op_word_t;
	// block fnum fb alg ams pms, pan lives in its own ring
	typedef logic [24:0] ch_word_t;

	localparam int SLOTS = 24;

	// operator index to pipeline stage
	localparam op_t OP_S1 = 2'd0;
	localparam op_t OP_S3 = 2'd1;
	localparam op_t OP_S2 = 2'd2;
	localparam op_t OP_S4 = 2'd3;

	// hole in the channel numbering
	localparam ch_t CH_UNUSED = 3'd3;
	// channel with per-operator frequency in special mode
	localparam ch_t CH_SPECIAL = 3'd2;

	// silent operator
	localparam tl_t  TL_RESET  = 7'd127;
	// left and right both on
	localparam pan_t PAN_RESET = 2'd3;

endpackage

`default_nettype wire

// ==== hdl/fm_reg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_reg_top import fm_reg_pkg::*; #(
	parameter int CH_STAGES = 6
) (
	input  wire        clk,
	input  wire        reset,
	input  wire        clk_en,
	input  wire  [7:0] din,
	input  ch_t        ch,
	input  op_t        op,
	input  wire        up_dt_mul,
	input  wire        up_tl,
	input  wire        up_ks_ar,
	input  wire        up_am_dr,
	input  wire        up_sr,
	input  wire        up_sl_rr,
	input  wire        up_ssg,
	input  wire        up_alg_fb,
	input  wire        up_fnum_lo,
	input  wire        up_pan_pms,
	input  wire  [5:0] latch_fnum,
	input  wire        effect,
	input  fnum_t      fnum_ch3op1,
	input  fnum_t      fnum_ch3op2,
	input  fnum_t      fnum_ch3op3,
	input  block_t     block_ch3op1,
	input  block_t     block_ch3op2,
	input  block_t     block_ch3op3,
	output logic       zero,
	output logic       s1_enters,
	output logic       s2_enters,
	output logic       s3_enters,
	output logic       s4_enters,
	output tl_t        tl,
	output dt_t        dt1,
	output nib_t       mul,
	output ks_t        ks,
	output rate_t      ar,
	output logic       amen,
	output rate_t      d1r,
	output rate_t      d2r,
	output nib_t       sl,
	output nib_t       rr,
	output logic       ssg_en,
	output block_t     ssg_eg,
	output fnum_t      fnum,
	output block_t     block,
	output alg_t       alg,
	output fb_t        fb,
	output pan_t       pan,
	output ams_t       ams,
	output pms_t       pms,
	output logic       mod_m1,
	output logic       mod_c1,
	output logic       mod_m2
);

	op_t    cur_op;
	ch_t    cur_ch;
	op_t    nxt_op;
	ch_t    nxt_ch;
	fnum_t  fnum_raw;
	block_t block_raw;

	// slot position for both memories and the combiner
	fm_slot_counter #(.CH_STAGES(CH_STAGES)) u_slot (
		.clk(clk), .reset(reset), .clk_en(clk_en),
		.cur_op(cur_op), .cur_ch(cur_ch), .nxt_op(nxt_op), .nxt_ch(nxt_ch),
		.zero(zero), .s1_enters(s1_enters), .s2_enters(s2_enters),
		.s3_enters(s3_enters), .s4_enters(s4_enters)
	);

	// per-operator fields go straight out
	fm_op_regs u_op_regs (
		.clk(clk), .reset(reset), .clk_en(clk_en), .din(din), .ch(ch), .op(op),
		.cur_op(cur_op), .cur_ch(cur_ch), .nxt_op(nxt_op), .nxt_ch(nxt_ch),
		.up_dt_mul(up_dt_mul), .up_tl(up_tl), .up_ks_ar(up_ks_ar),
		.up_am_dr(up_am_dr), .up_sr(up_sr), .up_sl_rr(up_sl_rr), .up_ssg(up_ssg),
		.tl(tl), .dt1(dt1), .mul(mul), .ks(ks), .ar(ar), .amen(amen),
		.d1r(d1r), .d2r(d2r), .sl(sl), .rr(rr), .ssg_en(ssg_en), .ssg_eg(ssg_eg)
	);

	// raw frequency goes through the combiner
	fm_ch_regs #(.CH_STAGES(CH_STAGES)) u_ch_regs (
		.clk(clk), .reset(reset), .clk_en(clk_en), .din(din), .ch(ch),
		.cur_ch(cur_ch), .latch_fnum(latch_fnum), .up_alg_fb(up_alg_fb),
		.up_fnum_lo(up_fnum_lo), .up_pan_pms(up_pan_pms),
		.fnum_raw(fnum_raw), .block_raw(block_raw), .alg(alg), .fb(fb),
		.ams(ams), .pms(pms), .pan(pan)
	);

	fm_slot_mux u_slot_mux (
		.cur_op(cur_op), .cur_ch(cur_ch), .alg(alg), .effect(effect),
		.fnum_raw(fnum_raw), .block_raw(block_raw),
		.fnum_ch3op1(fnum_ch3op1), .fnum_ch3op2(fnum_ch3op2), .fnum_ch3op3(fnum_ch3op3),
		.block_ch3op1(block_ch3op1), .block_ch3op2(block_ch3op2),
		.block_ch3op3(block_ch3op3),
		.fnum(fnum), .block(block), .mod_m1(mod_m1), .mod_c1(mod_c1), .mod_m2(mod_m2)
	);

endmodule

`default_nettype wire

// ==== hdl/fm_slot_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_slot_counter import fm_reg_pkg::*; #(
	parameter int CH_STAGES = 6
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  clk_en,
	output op_t  cur_op,
	output ch_t  cur_ch,
	output op_t  nxt_op,
	output ch_t  nxt_ch,
	output logic zero,
	output logic s1_enters,
	output logic s2_enters,
	output logic s3_enters,
	output logic s4_enters
);

	// three-channel variant stops after channel 2
	localparam ch_t LAST_CH = (CH_STAGES == 3) ? 3'd2 : 3'd6;

	logic last_ch;

	assign last_ch = cur_ch == LAST_CH;

	// next slot, channel first then operator
	always_comb begin
		nxt_op = last_ch ? cur_op + 2'd1 : cur_op;
		if (last_ch) begin
			nxt_ch = 3'd0;
		end else if (cur_ch + 3'd1 == CH_UNUSED) begin
			// jump over code 3
			nxt_ch = cur_ch + 3'd2;
		end else begin
			nxt_ch = cur_ch + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cur_op <= OP_S1;
			cur_ch <= 3'd0;
			zero   <= 1'b1;
		end else if (clk_en) begin
			cur_op <= nxt_op;
			cur_ch <= nxt_ch;
			// marks slot 0 in the same cycle as cur
			zero   <= (nxt_op == OP_S1) && (nxt_ch == 3'd0);
		end
	end

	// stage strobes, operator index order is S1 S3 S2 S4
	assign s1_enters = cur_op == OP_S1;
	assign s3_enters = cur_op == OP_S3;
	assign s2_enters = cur_op == OP_S2;
	assign s4_enters = cur_op == OP_S4;

endmodule

`default_nettype wire

// ==== hdl/fm_slot_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_slot_mux import fm_reg_pkg::*; (
	input  op_t    cur_op,
	input  ch_t    cur_ch,
	input  alg_t   alg,
	input  wire    effect,
	input  fnum_t  fnum_raw,
	input  block_t block_raw,
	input  fnum_t  fnum_ch3op1,
	input  fnum_t  fnum_ch3op2,
	input  fnum_t  fnum_ch3op3,
	input  block_t block_ch3op1,
	input  block_t block_ch3op2,
	input  block_t block_ch3op3,
	output fnum_t  fnum,
	output block_t block,
	output logic   mod_m1,
	output logic   mod_c1,
	output logic   mod_m2
);

	logic effect_on;
	logic st_m1;
	logic st_m2;
	logic st_c1;
	logic st_c2;

	// M1=S1, M2=S3, C1=S2, C2=S4
	assign st_m1 = cur_op == OP_S1;
	assign st_m2 = cur_op == OP_S3;
	assign st_c1 = cur_op == OP_S2;
	assign st_c2 = cur_op == OP_S4;

	assign effect_on = effect && (cur_ch == CH_SPECIAL);

	// special mode frequency, S4 keeps the channel value
	always_comb begin
		fnum  = fnum_raw;
		block = block_raw;
		if (effect_on && st_m1) begin
			fnum  = fnum_ch3op1;
			block = block_ch3op1;
		end else if (effect_on && st_c1) begin
			fnum  = fnum_ch3op2;
			block = block_ch3op2;
		end else if (effect_on && st_m2) begin
			fnum  = fnum_ch3op3;
			block = block_ch3op3;
		end
	end

	// modulation sources per algorithm, M1 never takes any
	always_comb begin
		mod_m1 = 1'b0;
		mod_c1 = 1'b0;
		mod_m2 = 1'b0;
		case (alg)
			3'd0: begin
				mod_c1 = st_m2;
				mod_m1 = st_c1;
				mod_m2 = st_c2;
			end
			3'd1: begin
				mod_m1 = st_m2;
				mod_c1 = st_m2;
				mod_m2 = st_c2;
			end
			3'd2: begin
				mod_c1 = st_m2;
				mod_m1 = st_c2;
				mod_m2 = st_c2;
			end
			3'd3: begin
				mod_m1 = st_c1;
				mod_c1 = st_c2;
				mod_m2 = st_c2;
			end
			3'd4: begin
				mod_m1 = st_c1;
				mod_m2 = st_c2;
			end
			// m1 fans out to the other three
			3'd5: mod_m1 = st_c1 || st_m2 || st_c2;
			3'd6: mod_m1 = st_c1;
			// all carriers, nothing modulated
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the register block testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module fm_reg_tb -o fm_reg_sim \
	|| { echo "build failed"; exit 1; }

./obj_dir/fm_reg_sim 2>&1 | tee sim.log

grep -q "Simulation completed successfully" sim.log && echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// ==== verif/fm_reg_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_reg_properties import fm_reg_pkg::*; (
	input wire  clk,
	input wire  reset,
	input wire  clk_en,
	input op_t  cur_op,
	input ch_t  cur_ch,
	input wire  zero,
	input wire  s1_enters,
	input wire  s2_enters,
	input wire  s3_enters,
	input wire  s4_enters,
	input pan_t pan
);

	// one stage at a time, handed over S1 S3 S2 S4 after channel 6
	a_stage_order: assert property (@(posedge clk) disable iff (reset)
		(clk_en && (cur_ch == 3'd6)) |=>
		($onehot({s1_enters, s2_enters, s3_enters, s4_enters}) &&
		({s1_enters, s3_enters, s2_enters, s4_enters} ==
		{$past(s4_enters), $past(s1_enters), $past(s3_enters), $past(s2_enters)})))
		else $error("stage strobes not one-hot or out of order");

	// round marker only at op 0 channel 0
	a_zero_slot: assert property (@(posedge clk) disable iff (reset)
		zero == ((cur_op == OP_S1) && (cur_ch == 3'd0)))
		else $error("zero out of step with slot");

	// codes 3 and 7 are holes
	a_no_hole: assert property (@(posedge clk) disable iff (reset)
		(cur_ch != CH_UNUSED) && (cur_ch != 3'd7))
		else $error("unused channel code reached");

	// skip from 2 straight to 4
	a_skip_3: assert property (@(posedge clk) disable iff (reset)
		(clk_en && (cur_ch == 3'd2)) |=> (cur_ch == 3'd4))
		else $error("channel 3 not skipped");

	// operator steps only after channel 6
	a_op_step: assert property (@(posedge clk) disable iff (reset)
		(clk_en && (cur_ch == 3'd6)) |=>
		((cur_ch == 3'd0) && (cur_op == op_t'($past(cur_op) + 2'd1))))
		else $error("operator did not step after channel 6");

	a_op_hold: assert property (@(posedge clk) disable iff (reset)
		(clk_en && (cur_ch != 3'd6)) |=> (cur_op == $past(cur_op)))
		else $error("operator changed inside a channel pass");

	// back at slot 0 with pan on both speakers
	a_reset_vals: assert property (@(posedge clk)
		reset |=> (zero && (cur_op == OP_S1) && (cur_ch == 3'd0) && (pan == PAN_RESET)))
		else $error("wrong values after reset");

endmodule

`default_nettype wire

// ==== verif/fm_reg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_reg_tb import fm_reg_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	// 40 rounds plus some slack
	localparam int WATCHDOG_NS = 40 * SLOTS * CLK_PERIOD + 20 * CLK_PERIOD;

	logic clk = 1'b0;
	logic reset, clk_en, effect;
	logic [7:0] din;
	ch_t ch;
	op_t op;
	logic up_dt_mul, up_tl, up_ks_ar, up_am_dr, up_sr, up_sl_rr, up_ssg;
	logic up_alg_fb, up_fnum_lo, up_pan_pms;
	logic [5:0] latch_fnum;
	fnum_t fnum_ch3op1, fnum_ch3op2, fnum_ch3op3;
	block_t block_ch3op1, block_ch3op2, block_ch3op3;
	logic zero, s1_enters, s2_enters, s3_enters, s4_enters;
	tl_t tl;
	dt_t dt1;
	nib_t mul, sl, rr;
	ks_t ks;
	rate_t ar, d1r, d2r;
	logic amen, ssg_en, mod_m1, mod_c1, mod_m2;
	block_t ssg_eg, block;
	fnum_t fnum;
	alg_t alg;
	fb_t fb;
	pan_t pan;
	ams_t ams;
	pms_t pms;

	// reference copies, per slot and per channel index
	tl_t tl_m [SLOTS];
	dt_t dt1_m [SLOTS];
	nib_t mul_m [SLOTS];
	ks_t ks_m [SLOTS];
	rate_t ar_m [SLOTS];
	logic amen_m [SLOTS];
	rate_t d1r_m [SLOTS];
	rate_t d2r_m [SLOTS];
	nib_t sl_m [SLOTS];
	nib_t rr_m [SLOTS];
	logic ssg_en_m [SLOTS];
	block_t ssg_eg_m [SLOTS];
	fnum_t fnum_m [6];
	block_t block_m [6];
	alg_t alg_m [6];
	fb_t fb_m [6];
	pan_t pan_m [6];
	ams_t ams_m [6];
	pms_t pms_m [6];

	int slot;
	int errors;
	logic checking;
	integer seed;

	fm_reg_top #(.CH_STAGES(6)) u_dut (.*);

	bind fm_reg_top fm_reg_properties u_props (
		.clk(clk), .reset(reset), .clk_en(clk_en), .cur_op(cur_op), .cur_ch(cur_ch),
		.zero(zero), .s1_enters(s1_enters), .s2_enters(s2_enters),
		.s3_enters(s3_enters), .s4_enters(s4_enters), .pan(pan)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// channel index 0..5 to code, 3 is skipped
	function automatic ch_t code_of(input int idx);
		return (idx < 3) ? ch_t'(idx) : ch_t'(idx + 1);
	endfunction

	// {mod_m1, mod_c1, mod_m2} from the algorithm diagrams
	function automatic logic [2:0] exp_mod(input alg_t a, input op_t o);
		logic m2;
		logic c1;
		logic c2;
		logic [2:0] f;
		m2 = o == 2'd1;
		c1 = o == 2'd2;
		c2 = o == 2'd3;
		case (a)
			3'd0: f = m2 ? 3'b010 : c1 ? 3'b100 : c2 ? 3'b001 : 3'b000;
			3'd1: f = m2 ? 3'b110 : c2 ? 3'b001 : 3'b000;
			3'd2: f = m2 ? 3'b010 : c2 ? 3'b101 : 3'b000;
			3'd3: f = c1 ? 3'b100 : c2 ? 3'b011 : 3'b000;
			3'd4: f = c1 ? 3'b100 : c2 ? 3'b001 : 3'b000;
			3'd5: f = (c1 || m2 || c2) ? 3'b100 : 3'b000;
			3'd6: f = c1 ? 3'b100 : 3'b000;
			default: f = 3'b000;
		endcase
		return f;
	endfunction

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("ERROR %s got 0x%0h expected 0x%0h at slot %0d", name, got, exp, slot);
			errors++;
		end
	endtask

	task automatic reset_model();
		for (int i = 0; i < SLOTS; i++) begin
			// silent operator, rest cleared
			tl_m[i] = TL_RESET;
			dt1_m[i] = '0;
			mul_m[i] = '0;
			ks_m[i] = '0;
			ar_m[i] = '0;
			amen_m[i] = 1'b0;
			d1r_m[i] = '0;
			d2r_m[i] = '0;
			sl_m[i] = '0;
			rr_m[i] = '0;
			ssg_en_m[i] = 1'b0;
			ssg_eg_m[i] = '0;
		end
		for (int c = 0; c < 6; c++) begin
			fnum_m[c] = '0;
			block_m[c] = '0;
			alg_m[c] = '0;
			fb_m[c] = '0;
			pan_m[c] = PAN_RESET;
			ams_m[c] = '0;
			pms_m[c] = '0;
		end
	endtask

	// write rule applied to the slot just left
	task automatic commit_write(input int s);
		int c;
		logic ch_hit;
		logic op_hit;
		c = s % 6;
		ch_hit = ch == code_of(c);
		op_hit = ch_hit && (op == op_t'(s / 6));
		if (op_hit && up_tl) begin
			tl_m[s] = din[6:0];
		end
		if (op_hit && up_dt_mul) begin
			dt1_m[s] = din[6:4];
			mul_m[s] = din[3:0];
		end
		if (op_hit && up_ks_ar) begin
			ks_m[s] = din[7:6];
			ar_m[s] = din[4:0];
		end
		if (op_hit && up_am_dr) begin
			amen_m[s] = din[7];
			d1r_m[s] = din[4:0];
		end
		if (op_hit && up_sr) begin
			d2r_m[s] = din[4:0];
		end
		if (op_hit && up_sl_rr) begin
			sl_m[s] = din[7:4];
			rr_m[s] = din[3:0];
		end
		if (op_hit && up_ssg) begin
			ssg_en_m[s] = din[3];
			ssg_eg_m[s] = din[2:0];
		end
		if (ch_hit && up_alg_fb) begin
			alg_m[c] = din[2:0];
			fb_m[c] = din[5:3];
		end
		// block and fnum high bits come from the latch
		if (ch_hit && up_fnum_lo) begin
			block_m[c] = latch_fnum[5:3];
			fnum_m[c] = {latch_fnum[2:0], din};
		end
		if (ch_hit && up_pan_pms) begin
			pan_m[c] = din[7:6];
			ams_m[c] = din[5:4];
			pms_m[c] = din[2:0];
		end
	endtask

	task automatic check_slot();
		int c;
		op_t o;
		fnum_t f_exp;
		block_t b_exp;
		logic [2:0] m_exp;
		c = slot % 6;
		o = op_t'(slot / 6);
		// position from own count
		check_val("zero", 16'(zero), 16'(slot == 0));
		check_val("s1_enters", 16'(s1_enters), 16'(o == 2'd0));
		check_val("s3_enters", 16'(s3_enters), 16'(o == 2'd1));
		check_val("s2_enters", 16'(s2_enters), 16'(o == 2'd2));
		check_val("s4_enters", 16'(s4_enters), 16'(o == 2'd3));
		if (checking) begin
			check_val("tl", 16'(tl), 16'(tl_m[slot]));
			check_val("dt1", 16'(dt1), 16'(dt1_m[slot]));
			check_val("mul", 16'(mul), 16'(mul_m[slot]));
			check_val("ks", 16'(ks), 16'(ks_m[slot]));
			check_val("ar", 16'(ar), 16'(ar_m[slot]));
			check_val("amen", 16'(amen), 16'(amen_m[slot]));
			check_val("d1r", 16'(d1r), 16'(d1r_m[slot]));
			check_val("d2r", 16'(d2r), 16'(d2r_m[slot]));
			check_val("sl", 16'(sl), 16'(sl_m[slot]));
			check_val("rr", 16'(rr), 16'(rr_m[slot]));
			check_val("ssg_en", 16'(ssg_en), 16'(ssg_en_m[slot]));
			check_val("ssg_eg", 16'(ssg_eg), 16'(ssg_eg_m[slot]));
			f_exp = fnum_m[c];
			b_exp = block_m[c];
			// special mode, S1 S2 S3 of channel 2 only
			if (effect && (c == 2)) begin
				case (o)
					2'd0: begin
						f_exp = fnum_ch3op1;
						b_exp = block_ch3op1;
					end
					2'd2: begin
						f_exp = fnum_ch3op2;
						b_exp = block_ch3op2;
					end
					2'd1: begin
						f_exp = fnum_ch3op3;
						b_exp = block_ch3op3;
					end
					default: ;
				endcase
			end
			check_val("fnum", 16'(fnum), 16'(f_exp));
			check_val("block", 16'(block), 16'(b_exp));
			check_val("alg", 16'(alg), 16'(alg_m[c]));
			check_val("fb", 16'(fb), 16'(fb_m[c]));
			check_val("pan", 16'(pan), 16'(pan_m[c]));
			check_val("ams", 16'(ams), 16'(ams_m[c]));
			check_val("pms", 16'(pms), 16'(pms_m[c]));
			m_exp = exp_mod(alg_m[c], o);
			check_val("mod_m1", 16'(mod_m1), 16'(m_exp[2]));
			check_val("mod_c1", 16'(mod_c1), 16'(m_exp[1]));
			check_val("mod_m2", 16'(mod_m2), 16'(m_exp[0]));
		end
	endtask

	// inputs seen at the last rising edge belong to the slot just left
	task automatic step();
		@(negedge clk);
		commit_write(slot);
		slot = (slot + 1) % SLOTS;
		check_slot();
	endtask

	task automatic run_round();
		repeat (SLOTS) step();
	endtask

	task automatic pick_target();
		logic [31:0] r;
		int idx;
		r = $random(seed);
		idx = r[7:0] % 6;
		ch = code_of(idx);
		op = r[9:8];
		din = r[23:16];
	endtask

	task automatic set_op_up(input int grp, input logic v);
		case (grp)
			0: up_dt_mul = v;
			1: up_tl = v;
			2: up_ks_ar = v;
			3: up_am_dr = v;
			4: up_sr = v;
			5: up_sl_rr = v;
			default: up_ssg = v;
		endcase
	endtask

	task automatic init_inputs();
		reset = 1'b1;
		clk_en = 1'b1;
		din = '0;
		ch = '0;
		op = '0;
		for (int g = 0; g < 7; g++) begin
			set_op_up(g, 1'b0);
		end
		up_alg_fb = 1'b0;
		up_fnum_lo = 1'b0;
		up_pan_pms = 1'b0;
		latch_fnum = '0;
		effect = 1'b0;
		fnum_ch3op1 = '0;
		fnum_ch3op2 = '0;
		fnum_ch3op3 = '0;
		block_ch3op1 = '0;
		block_ch3op2 = '0;
		block_ch3op3 = '0;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, run still going after %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		seed = 32'h6642_9c38;
		errors = 0;
		checking = 1'b0;
		slot = 0;
		init_inputs();
		reset_model();
		repeat (2) @(negedge clk);
		reset = 1'b0;
		// RAM fill still running in this round
		run_round();
		checking = 1'b1;
		run_round();
		// one operator group per round, seen in the following round
		for (int g = 0; g < 7; g++) begin
			pick_target();
			set_op_up(g, 1'b1);
			run_round();
			set_op_up(g, 1'b0);
		end
		run_round();
		// every algorithm once
		for (int a = 0; a < 8; a++) begin
			pick_target();
			din[2:0] = 3'(a);
			up_alg_fb = 1'b1;
			run_round();
			up_alg_fb = 1'b0;
		end
		repeat (2) begin
			pick_target();
			latch_fnum = 6'($random(seed));
			up_fnum_lo = 1'b1;
			run_round();
			up_fnum_lo = 1'b0;
		end
		repeat (2) begin
			pick_target();
			up_pan_pms = 1'b1;
			run_round();
			up_pan_pms = 1'b0;
		end
		// channel 2 gets its own fnum before special mode
		pick_target();
		ch = CH_SPECIAL;
		latch_fnum = 6'($random(seed));
		up_fnum_lo = 1'b1;
		run_round();
		up_fnum_lo = 1'b0;
		effect = 1'b1;
		fnum_ch3op1 = fnum_t'($random(seed));
		fnum_ch3op2 = fnum_t'($random(seed));
		fnum_ch3op3 = fnum_t'($random(seed));
		block_ch3op1 = block_t'($random(seed));
		block_ch3op2 = block_t'($random(seed));
		block_ch3op3 = block_t'($random(seed));
		repeat (2) run_round();
		effect = 1'b0;
		repeat (2) run_round();
		$display("checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
